//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbCore
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "no pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
logic/cpuPkg.sv
logic/alu.sv
logic/regFile.sv
logic/pcUnit.sv
logic/operandStage.sv
logic/controlUnit.sv
logic/mipsCore.sv
sim/tbClock.sv
sim/tbCore.sv

//--- logic/alu.sv
module alu (
    input  logic [31:0] aluA,
    input  logic [31:0] aluB,
    input  logic [1:0]  aluOp,
    output logic [31:0] aluResult,
    output logic        zero,
    output logic        overflow
);
    import cpuPkg::*;

    logic        subtract;
    logic [31:0] bOperand;
    logic [31:0] sum;
    logic        sumOvf;

    // slt shares the subtractor
    assign subtract = (aluOp == aluSub) || (aluOp == aluSlt);
    assign bOperand = subtract ? ~aluB : aluB;
    assign sum      = aluA + bOperand + {31'd0, subtract};
    assign sumOvf   = (aluA[31] == bOperand[31]) && (sum[31] != aluA[31]);

    always_comb begin
        case (aluOp)
            aluAnd:  aluResult = aluA & aluB;
            aluSlt:  aluResult = {31'd0, sum[31] ^ sumOvf}; // signed less-than
            default: aluResult = sum;
        endcase
    end

    assign zero     = (aluResult == 32'd0);
    assign overflow = sumOvf && (aluOp == aluAdd || aluOp == aluSub);

endmodule

//--- logic/controlUnit.sv
module controlUnit (
    input  logic             clk,
    input  logic             arstN,
    input  cpuPkg::instrWord instr,
    input  logic             zero,
    input  logic             overflow,
    output logic             pcWrite,
    output logic [2:0]       pcSrc,
    output logic             epcWrite,
    output logic             irWrite,
    output logic             regLoad,
    output logic             aluOutWrite,
    output logic             mdrLoad,
    output logic             memRead,
    output logic             memWrite,
    output logic             addrFromAlu,
    output logic             aluSrcA,
    output logic [1:0]       aluSrcB,
    output logic [1:0]       aluOp,
    output logic             regWrite,
    output logic             regDstRd,
    output logic             wbSel
);
    import cpuPkg::*;

    localparam logic [4:0] sReset      = 5'd0;
    localparam logic [4:0] sFetch      = 5'd1;
    localparam logic [4:0] sLoadIr     = 5'd2;
    localparam logic [4:0] sDecode     = 5'd3;
    localparam logic [4:0] sExec       = 5'd4;
    localparam logic [4:0] sWriteBack  = 5'd5;
    localparam logic [4:0] sExecI      = 5'd6;
    localparam logic [4:0] sWriteBackI = 5'd7;
    localparam logic [4:0] sAddr       = 5'd8;
    localparam logic [4:0] sMemRead    = 5'd9;
    localparam logic [4:0] sMemLatch   = 5'd10;
    localparam logic [4:0] sWriteLoad  = 5'd11;
    localparam logic [4:0] sMemWrite   = 5'd12;
    localparam logic [4:0] sBranch     = 5'd13;
    localparam logic [4:0] sJump       = 5'd14;
    localparam logic [4:0] sReturn     = 5'd15;
    localparam logic [4:0] sExcept     = 5'd16;

    logic [4:0] state;
    logic [4:0] nextState;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       rtypeLegal;
    logic       trapsOnOvf;

    assign opcode     = instr.r.opcode;
    assign funct      = instr.r.funct;
    assign rtypeLegal = (funct == fnAdd) || (funct == fnSub) ||
                        (funct == fnAnd) || (funct == fnSlt);
    assign trapsOnOvf = (funct == fnAdd) || (funct == fnSub); // slt and and never trap

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sReset;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = sFetch;
        case (state)
            sFetch:  nextState = sLoadIr;
            sLoadIr: nextState = sDecode;
            sDecode: begin
                case (opcode)
                    opSpecial: begin
                        if (funct == fnRte) begin
                            nextState = sReturn;
                        end else if (rtypeLegal) begin
                            nextState = sExec;
                        end else begin
                            nextState = sExcept;
                        end
                    end
                    opAddi, opAddiu: nextState = sExecI;
                    opLw, opSw:      nextState = sAddr;
                    opBeq, opBne:    nextState = sBranch;
                    opJ:             nextState = sJump;
                    default:         nextState = sExcept; // illegal opcode
                endcase
            end
            sExec:     nextState = (trapsOnOvf && overflow) ? sExcept : sWriteBack;
            sExecI:    nextState = (opcode == opAddi && overflow) ? sExcept : sWriteBackI;
            sAddr:     nextState = (opcode == opSw) ? sMemWrite : sMemRead;
            sMemRead:  nextState = sMemLatch;
            sMemLatch: nextState = sWriteLoad;
            default:   nextState = sFetch;
        endcase
    end

    always_comb begin
        pcWrite     = 1'b0;
        pcSrc       = pcSeq;
        epcWrite    = 1'b0;
        irWrite     = 1'b0;
        regLoad     = 1'b0;
        aluOutWrite = 1'b0;
        mdrLoad     = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        addrFromAlu = 1'b0;
        aluSrcA     = srcAPc;
        aluSrcB     = srcBFour;
        aluOp       = aluAdd;
        regWrite    = 1'b0;
        regDstRd    = 1'b0;
        wbSel       = wbAluOut;
        case (state)
            sFetch: begin
                memRead = 1'b1;
                pcWrite = 1'b1; // pc + 4 from the alu
            end
            sLoadIr: irWrite = 1'b1;
            sDecode: begin
                regLoad     = 1'b1;
                aluSrcB     = srcBBranch;
                aluOutWrite = 1'b1; // branch target, used only by beq/bne
            end
            sExec: begin
                aluSrcA     = srcAReg;
                aluSrcB     = srcBReg;
                aluOutWrite = 1'b1;
                case (funct)
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnSlt:   aluOp = aluSlt;
                    default: aluOp = aluAdd;
                endcase
            end
            sWriteBack: begin
                regWrite = 1'b1;
                regDstRd = 1'b1;
            end
            sExecI, sAddr: begin
                aluSrcA     = srcAReg;
                aluSrcB     = srcBImm;
                aluOutWrite = 1'b1;
            end
            sWriteBackI: regWrite = 1'b1;
            sMemRead: begin
                memRead     = 1'b1;
                addrFromAlu = 1'b1;
            end
            sMemLatch: mdrLoad = 1'b1;
            sWriteLoad: begin
                regWrite = 1'b1;
                wbSel    = wbMem;
            end
            sMemWrite: begin
                memWrite    = 1'b1;
                addrFromAlu = 1'b1;
            end
            sBranch: begin
                aluSrcA = srcAReg;
                aluSrcB = srcBReg;
                aluOp   = aluSub;
                pcSrc   = pcAluOut;
                pcWrite = (opcode == opBeq) ? zero : !zero;
            end
            sJump: begin
                pcSrc   = pcJump;
                pcWrite = 1'b1;
            end
            sReturn: begin
                pcSrc   = pcEpc;
                pcWrite = 1'b1;
            end
            sExcept: begin
                epcWrite = 1'b1; // pc already points past the faulting instr
                pcSrc    = pcHandler;
                pcWrite  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddi    = 6'h08;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct field under opSpecial
    localparam logic [5:0] fnRte = 6'h13;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnSlt = 6'h2a;

    localparam logic [1:0] aluAdd = 2'd0;
    localparam logic [1:0] aluSub = 2'd1;
    localparam logic [1:0] aluAnd = 2'd2;
    localparam logic [1:0] aluSlt = 2'd3;

    localparam logic srcAPc  = 1'b0;
    localparam logic srcAReg = 1'b1;

    localparam logic [1:0] srcBReg    = 2'd0;
    localparam logic [1:0] srcBFour   = 2'd1;
    localparam logic [1:0] srcBImm    = 2'd2;
    localparam logic [1:0] srcBBranch = 2'd3; // sign-extended imm << 2

    localparam logic [2:0] pcSeq     = 3'd0;
    localparam logic [2:0] pcAluOut  = 3'd1;
    localparam logic [2:0] pcJump    = 3'd2;
    localparam logic [2:0] pcHandler = 3'd3;
    localparam logic [2:0] pcEpc     = 3'd4;

    localparam logic wbAluOut = 1'b0;
    localparam logic wbMem    = 1'b1;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    // j target spans rs, rt and imm
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

endpackage

//--- logic/mipsCore.sv
module mipsCore #(
    parameter logic [31:0] resetAddr   = 32'h0000_0000,
    parameter logic [31:0] handlerAddr = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] memRdata,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata,
    output logic        memRead,
    output logic        memWrite
);
    import cpuPkg::*;

    instrWord    instr;
    logic        zero;
    logic        overflow;
    logic        pcWrite;
    logic [2:0]  pcSrc;
    logic        epcWrite;
    logic        irWrite;
    logic        regLoad;
    logic        aluOutWrite;
    logic        mdrLoad;
    logic        addrFromAlu;
    logic        aluSrcA;
    logic [1:0]  aluSrcB;
    logic [1:0]  aluOp;
    logic        regWrite;
    logic        regDstRd;
    logic        wbSel;
    logic [31:0] pc;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] aluOutReg;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] wbData;
    logic [4:0]  wbAddr;

    controlUnit ctrl (
        .clk(clk), .arstN(arstN), .instr(instr), .zero(zero), .overflow(overflow),
        .pcWrite(pcWrite), .pcSrc(pcSrc), .epcWrite(epcWrite), .irWrite(irWrite),
        .regLoad(regLoad), .aluOutWrite(aluOutWrite), .mdrLoad(mdrLoad),
        .memRead(memRead), .memWrite(memWrite), .addrFromAlu(addrFromAlu),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp), .regWrite(regWrite),
        .regDstRd(regDstRd), .wbSel(wbSel)
    );

    pcUnit #(.resetAddr(resetAddr), .handlerAddr(handlerAddr)) pcU (
        .clk(clk), .arstN(arstN), .pcWrite(pcWrite), .pcSrc(pcSrc), .epcWrite(epcWrite),
        .aluResult(aluResult), .aluOutReg(aluOutReg),
        .jumpTarget({instr.i.rs, instr.i.rt, instr.i.imm}), .pc(pc), .epc()
    );

    operandStage ops (
        .clk(clk), .arstN(arstN), .irWrite(irWrite), .regLoad(regLoad),
        .aluOutWrite(aluOutWrite), .mdrLoad(mdrLoad), .addrFromAlu(addrFromAlu),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .wbSel(wbSel), .regDstRd(regDstRd),
        .memRdata(memRdata), .pc(pc), .rsData(rsData), .rtData(rtData),
        .aluResult(aluResult), .instr(instr), .aluA(aluA), .aluB(aluB),
        .aluOutReg(aluOutReg), .memAddr(memAddr), .memWdata(memWdata),
        .wbData(wbData), .wbAddr(wbAddr)
    );

    regFile regs (
        .clk(clk), .arstN(arstN), .regWrite(regWrite), .rsAddr(instr.r.rs),
        .rtAddr(instr.r.rt), .wbAddr(wbAddr), .wbData(wbData),
        .rsData(rsData), .rtData(rtData)
    );

    alu aluU (
        .aluA(aluA), .aluB(aluB), .aluOp(aluOp),
        .aluResult(aluResult), .zero(zero), .overflow(overflow)
    );

endmodule

//--- logic/operandStage.sv
module operandStage (
    input  logic             clk,
    input  logic             arstN,
    input  logic             irWrite,
    input  logic             regLoad,
    input  logic             aluOutWrite,
    input  logic             mdrLoad,
    input  logic             addrFromAlu,
    input  logic             aluSrcA,
    input  logic [1:0]       aluSrcB,
    input  logic             wbSel,
    input  logic             regDstRd,
    input  logic [31:0]      memRdata,
    input  logic [31:0]      pc,
    input  logic [31:0]      rsData,
    input  logic [31:0]      rtData,
    input  logic [31:0]      aluResult,
    output cpuPkg::instrWord instr,
    output logic [31:0]      aluA,
    output logic [31:0]      aluB,
    output logic [31:0]      aluOutReg,
    output logic [31:0]      memAddr,
    output logic [31:0]      memWdata,
    output logic [31:0]      wbData,
    output logic [4:0]       wbAddr
);
    import cpuPkg::*;

    logic [31:0] aReg;
    logic [31:0] bReg;
    logic [31:0] mdrReg;
    logic [31:0] immExt;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instr <= '0;
        end else if (irWrite) begin
            instr <= memRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (regLoad) begin
            aReg <= rsData;
            bReg <= rtData;
        end
        if (aluOutWrite) aluOutReg <= aluResult;
        if (mdrLoad) mdrReg <= memRdata;
    end

    assign immExt = {{16{instr.i.imm[15]}}, instr.i.imm};

    assign aluA = (aluSrcA == srcAReg) ? aReg : pc;

    always_comb begin
        case (aluSrcB)
            srcBReg:    aluB = bReg;
            srcBFour:   aluB = 32'd4;
            srcBImm:    aluB = immExt;
            srcBBranch: aluB = {immExt[29:0], 2'b00};
            default:    aluB = bReg;
        endcase
    end

    assign memAddr  = addrFromAlu ? aluOutReg : pc;
    assign memWdata = bReg; // sw data is rt
    assign wbData   = (wbSel == wbMem) ? mdrReg : aluOutReg;
    assign wbAddr   = regDstRd ? instr.r.rd : instr.r.rt;

endmodule

//--- logic/pcUnit.sv
module pcUnit #(
    parameter logic [31:0] resetAddr   = 32'h0000_0000,
    parameter logic [31:0] handlerAddr = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        pcWrite,
    input  logic [2:0]  pcSrc,
    input  logic        epcWrite,
    input  logic [31:0] aluResult,
    input  logic [31:0] aluOutReg,
    input  logic [25:0] jumpTarget,
    output logic [31:0] pc,
    output logic [31:0] epc
);
    import cpuPkg::*;

    logic [31:0] pcNext;

    always_comb begin
        case (pcSrc)
            pcSeq:     pcNext = aluResult; // pc + 4 computed in fetch
            pcAluOut:  pcNext = aluOutReg;
            pcJump:    pcNext = {pc[31:28], jumpTarget, 2'b00};
            pcHandler: pcNext = handlerAddr;
            pcEpc:     pcNext = epc;
            default:   pcNext = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetAddr;
        end else if (pcWrite) begin
            pc <= pcNext;
        end
    end

    // return address for rte
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            epc <= 32'd0;
        end else if (epcWrite) begin
            epc <= pc;
        end
    end

endmodule

//--- logic/regFile.sv
module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic        regWrite,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  wbAddr,
    input  logic [31:0] wbData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (regWrite && wbAddr != 5'd0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // $zero is hardwired
    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

//--- sim/tbClock.sv
module tbClock #(
    parameter int halfPeriod = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #halfPeriod clk = ~clk; // 40-unit period

endmodule

//--- sim/tbCore.sv
module tbCore;
    import cpuPkg::*;

    localparam logic [31:0] resetAddr   = 32'h0000_0040;
    localparam logic [31:0] handlerAddr = 32'h0000_0200;
    localparam logic [31:0] trapAddr    = 32'h0000_03f0; // only a stray exception writes here
    localparam logic [31:0] markAddr    = 32'h0000_03f4;
    localparam logic [31:0] doneAddr    = 32'h0000_03fc;

    logic        clk;
    logic        arstN;
    logic [31:0] memRdata = '0;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic        memRead;
    logic        memWrite;

    logic [31:0] mem [256];
    logic [31:0] wrAddr [$];
    logic [31:0] wrData [$];
    logic [31:0] readLog [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic        doneSeen = 1'b0;
    logic [15:0] lfsrState = 16'd56245;
    int          codeIdx = 0;
    int          cycleCount = 0;
    int          cycleLimit = 200;
    int          testErrors = 0;
    int          totalErrors = 0;
    int          passCount = 0;
    int          failCount = 0;

    tbClock clkGen (.clk(clk));

    mipsCore #(.resetAddr(resetAddr), .handlerAddr(handlerAddr)) DUT (
        .clk(clk), .arstN(arstN), .memRdata(memRdata), .memAddr(memAddr),
        .memWdata(memWdata), .memRead(memRead), .memWrite(memWrite)
    );

    // memory answers a read strobe on the same edge, data held until the next read
    always @(posedge clk) begin
        if (memRead) begin
            memRdata <= mem[memAddr[9:2]];
            readLog.push_back(memAddr);
        end
        if (memWrite) begin
            mem[memAddr[9:2]] = memWdata;
            wrAddr.push_back(memAddr);
            wrData.push_back(memWdata);
            doneSeen = doneSeen || (memAddr == doneAddr);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no final store after %0d cycles", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    // galois lfsr, taps 16,14,13,11
    function automatic logic nextBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = {1'b0, lfsrState[15:1]} ^ (outBit ? 16'hb400 : 16'h0000);
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    // small enough that add and sub of two of them never overflow
    function automatic logic [31:0] smallSigned();
        logic [31:0] v;
        v = randBits(30);
        return {{2{v[29]}}, v[29:0]};
    endfunction

    function automatic logic [31:0] rInstr(input int rs, input int rt, input int rd,
                                           input logic [5:0] fn);
        return {opSpecial, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] iInstr(input logic [5:0] op, input int rs, input int rt,
                                           input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jInstr(input int target);
        return {opJ, target[25:0]};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[codeIdx[7:0]] = word;
        codeIdx++;
        cycleLimit += 7; // worst case is lw
    endtask

    task automatic expectWrite(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // holds the core in reset while memory is refilled
    task automatic startProgram();
        @(negedge clk);
        arstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = ~(i * 32'h9e37_79b9);
        end
        expAddr.delete();
        expData.delete();
        testErrors = 0;
        codeIdx = int'(handlerAddr >> 2);
        emit(iInstr(opSw, 0, 0, trapAddr));
        emit(iInstr(opSw, 0, 0, doneAddr));
        emit(jInstr(codeIdx));
        codeIdx = int'(resetAddr >> 2);
    endtask

    task automatic placeHandler(input int marker);
        int saved;
        saved = codeIdx;
        codeIdx = int'(handlerAddr >> 2);
        emit(iInstr(opAddiu, 0, 20, marker));
        emit(iInstr(opSw, 0, 20, markAddr));
        emit(rInstr(0, 0, 0, fnRte));
        codeIdx = saved;
    endtask

    task automatic runAndCheck();
        emit(iInstr(opSw, 0, 0, doneAddr));
        expectWrite(doneAddr, 32'd0);
        emit(jInstr(codeIdx)); // park after the final store
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            assert (!memRead && !memWrite) else begin
                $display("** Error at time %0t: memory strobe active during reset", $time);
                testErrors++;
            end
        end
        arstN = 1'b1;
        wrAddr.delete();
        wrData.delete();
        readLog.delete();
        doneSeen = 1'b0;
        while (!memRead) begin
            @(negedge clk);
        end
        assert (memAddr == resetAddr) else begin
            $display("** Error at time %0t: first fetch from %h, expected %h",
                     $time, memAddr, resetAddr);
            testErrors++;
        end
        while (!doneSeen) begin
            @(negedge clk);
        end
        for (int i = 0; i < expAddr.size(); i++) begin
            assert (i < wrAddr.size()) else begin
                $display("expected write of %h to address %h never happened",
                         expData[i], expAddr[i]);
                testErrors++;
            end
            if (i < wrAddr.size()) begin
                assert (wrAddr[i] == expAddr[i] && wrData[i] == expData[i]) else begin
                    $display("** Error at time %0t: address %h got %h, expected %h at %h",
                             $time, wrAddr[i], wrData[i], expData[i], expAddr[i]);
                    testErrors++;
                end
            end
        end
        assert (wrAddr.size() <= expAddr.size()) else begin
            $display("core made %0d writes where %0d were expected",
                     wrAddr.size(), expAddr.size());
            testErrors++;
        end
    endtask

    task automatic checkNextFetch(input logic [31:0] fromAddr, input logic [31:0] wantAddr);
        int idx;
        idx = -1;
        for (int i = 0; i + 1 < readLog.size(); i++) begin
            if (idx < 0 && readLog[i] == fromAddr) begin
                idx = i;
            end
        end
        assert (idx >= 0) else begin
            $display("instruction at %h was never fetched", fromAddr);
            testErrors++;
        end
        if (idx >= 0) begin
            assert (readLog[idx + 1] == wantAddr) else begin
                $display("** Error at time %0t: fetch after %h went to %h, expected %h",
                         $time, fromAddr, readLog[idx + 1], wantAddr);
                testErrors++;
            end
        end
    endtask

    task automatic reportTest(input string name);
        totalErrors += testErrors;
        if (testErrors == 0) begin
            passCount++;
            $display("%s: passed", name);
        end else begin
            failCount++;
            $display("%s: failed with %0d errors", name, testErrors);
        end
    endtask

    task automatic resetState();
        startProgram();
        emit(iInstr(opSw, 0, 5, 'h310)); // registers come out of reset cleared
        expectWrite(32'h310, 32'd0);
        runAndCheck();
        reportTest("resetState");
    endtask

    task automatic rtypeArith();
        logic [31:0] a;
        logic [31:0] b;
        a = smallSigned();
        b = smallSigned();
        startProgram();
        mem[8'hc0] = a;
        mem[8'hc1] = b;
        emit(iInstr(opLw, 0, 1, 'h300));
        emit(iInstr(opLw, 0, 2, 'h304));
        emit(rInstr(1, 2, 3, fnAdd));
        emit(iInstr(opSw, 0, 3, 'h310));
        emit(rInstr(1, 2, 4, fnSub));
        emit(iInstr(opSw, 0, 4, 'h314));
        emit(rInstr(1, 2, 5, fnAnd));
        emit(iInstr(opSw, 0, 5, 'h318));
        emit(rInstr(1, 2, 6, fnSlt));
        emit(iInstr(opSw, 0, 6, 'h31c));
        emit(rInstr(2, 1, 7, fnSlt));
        emit(iInstr(opSw, 0, 7, 'h320));
        expectWrite(32'h310, a + b);
        expectWrite(32'h314, a - b);
        expectWrite(32'h318, a & b);
        expectWrite(32'h31c, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expectWrite(32'h320, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        runAndCheck();
        reportTest("rtypeArith");
    endtask

    task automatic immediateRoundTrip();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        x = smallSigned();
        y = 32'h7fff_ff00 | randBits(8); // plus 0x7fff always wraps
        z = randBits(32);
        startProgram();
        mem[8'hc0] = x;
        mem[8'hc1] = y;
        mem[8'hc2] = z;
        emit(iInstr(opLw, 0, 1, 'h300));
        emit(iInstr(opAddi, 1, 2, -5));
        emit(iInstr(opSw, 0, 2, 'h310));
        emit(iInstr(opAddiu, 0, 3, -1234));
        emit(iInstr(opSw, 0, 3, 'h314));
        emit(iInstr(opLw, 0, 4, 'h304));
        emit(iInstr(opAddiu, 4, 5, 'h7fff));
        emit(iInstr(opSw, 0, 5, 'h318));
        emit(iInstr(opLw, 0, 6, 'h308));
        emit(iInstr(opSw, 0, 6, 'h31c));
        emit(iInstr(opLw, 0, 7, 'h31c));
        emit(iInstr(opSw, 0, 7, 'h320));
        expectWrite(32'h310, x - 32'd5);
        expectWrite(32'h314, 32'hffff_fb2e);
        expectWrite(32'h318, y + 32'h0000_7fff);
        expectWrite(32'h31c, z);
        expectWrite(32'h320, z);
        runAndCheck();
        reportTest("immediateRoundTrip");
    endtask

    // branch over one store, then a store that always happens
    task automatic branchCase(input logic [5:0] op, input int rs, input int rt,
                              input logic [31:0] vs, input logic [31:0] vt,
                              input logic [31:0] skipAddr, input logic [31:0] afterAddr);
        logic taken;
        taken = (op == opBeq) ? (vs == vt) : (vs != vt);
        emit(iInstr(op, rs, rt, 1));
        emit(iInstr(opSw, 0, 11, skipAddr));
        emit(iInstr(opSw, 0, 10, afterAddr));
        if (!taken) begin
            expectWrite(skipAddr, 32'h22);
        end
        expectWrite(afterAddr, 32'h11);
    endtask

    task automatic branchJump();
        logic [31:0] p;
        logic [31:0] q;
        p = randBits(32);
        q = p ^ (randBits(8) | 32'd1);
        startProgram();
        mem[8'hc0] = p;
        mem[8'hc1] = p;
        mem[8'hc2] = q;
        emit(iInstr(opLw, 0, 1, 'h300));
        emit(iInstr(opLw, 0, 2, 'h304));
        emit(iInstr(opLw, 0, 3, 'h308));
        emit(iInstr(opAddiu, 0, 10, 'h11));
        emit(iInstr(opAddiu, 0, 11, 'h22));
        branchCase(opBeq, 1, 2, p, p, 32'h310, 32'h314);
        branchCase(opBeq, 1, 3, p, q, 32'h318, 32'h31c);
        branchCase(opBne, 1, 3, p, q, 32'h320, 32'h324);
        branchCase(opBne, 1, 2, p, p, 32'h328, 32'h32c);
        emit(jInstr(codeIdx + 2));
        emit(iInstr(opSw, 0, 11, 'h330)); // jumped over
        runAndCheck();
        reportTest("branchJump");
    endtask

    task automatic overflowTrap();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addAt;
        a = 32'h7000_0000 | randBits(16);
        b = 32'h4000_0000 | randBits(16);
        startProgram();
        mem[8'hc0] = a;
        mem[8'hc1] = b;
        emit(iInstr(opLw, 0, 1, 'h300));
        emit(iInstr(opLw, 0, 2, 'h304));
        emit(iInstr(opAddiu, 0, 3, 'h55));
        addAt = codeIdx * 4;
        emit(rInstr(1, 2, 3, fnAdd));
        emit(iInstr(opSw, 0, 3, 'h310));
        placeHandler('h77);
        expectWrite(markAddr, 32'h77);
        expectWrite(32'h310, 32'h55); // destination keeps its old value
        runAndCheck();
        checkNextFetch(addAt, handlerAddr);
        checkNextFetch(handlerAddr + 32'd8, addAt + 32'd4);
        reportTest("overflowTrap");
    endtask

    task automatic illegalOpcode();
        logic [31:0] badAt;
        startProgram();
        emit(iInstr(opAddiu, 0, 3, 'h66));
        badAt = codeIdx * 4;
        emit(iInstr(6'h3f, 0, 3, 'h1234)); // rt field would name $3
        emit(iInstr(opSw, 0, 3, 'h310));
        placeHandler('h88);
        expectWrite(markAddr, 32'h88);
        expectWrite(32'h310, 32'h66);
        runAndCheck();
        checkNextFetch(badAt, handlerAddr);
        checkNextFetch(handlerAddr + 32'd8, badAt + 32'd4);
        reportTest("illegalOpcode");
    endtask

    initial begin
        arstN = 1'b0;
        rtypeArith();
        immediateRoundTrip();
        branchJump();
        overflowTrap();
        illegalOpcode();
        resetState(); // runs after earlier programs left registers nonzero
        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 passCount + failCount, passCount, failCount, totalErrors);
        if (failCount == 0 && totalErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
